// File: rtl/axi_ic_pkg.sv
`default_nettype none

package axi_ic_pkg;

  // one master fans out to this many fixed address regions
  parameter int unsigned NUM_SLAVES = 4;

  parameter int unsigned ADDR_BITS = 40;  // width of every region bound below

  // slave 0, on-chip memory
  parameter logic [ADDR_BITS-1:0] sram_start = 40'h00_0000_0000;
  parameter logic [ADDR_BITS-1:0] sram_end = 40'h00_01FF_FFFF;

  // slave 1, hole between memory and peripherals
  parameter logic [ADDR_BITS-1:0] err1_start = 40'h00_0200_0000;
  parameter logic [ADDR_BITS-1:0] err1_end = 40'h00_0FFF_FFFF;

  // slave 2, peripheral bridge
  parameter logic [ADDR_BITS-1:0] periph_start = 40'h00_1000_0000;
  parameter logic [ADDR_BITS-1:0] periph_end = 40'h00_1FFF_FFFF;

  // slave 3, everything above the peripherals
  parameter logic [ADDR_BITS-1:0] err2_start = 40'h00_2000_0000;
  parameter logic [ADDR_BITS-1:0] err2_end = 40'hFF_FFFF_FFFF;

  typedef logic [NUM_SLAVES-1:0] slave_sel_t;  // bit i selects slave i

  typedef logic [1:0] resp_t;  // bresp and rresp encoding

endpackage

`default_nettype wire

// File: rtl/addr_route.sv
`default_nettype none

module addr_route #(
  parameter int unsigned ADDR_W = axi_ic_pkg::ADDR_BITS
) (
  input  wire logic [ADDR_W-1:0]                    addr,
  input  wire logic                                 valid,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]    ready_s,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]    valid_s,
  output logic                                      ready,
  output axi_ic_pkg::slave_sel_t                    sel
);

  localparam logic [axi_ic_pkg::ADDR_BITS-1:0] region_lo [axi_ic_pkg::NUM_SLAVES] = '{
    axi_ic_pkg::sram_start,
    axi_ic_pkg::err1_start,
    axi_ic_pkg::periph_start,
    axi_ic_pkg::err2_start
  };

  localparam logic [axi_ic_pkg::ADDR_BITS-1:0] region_hi [axi_ic_pkg::NUM_SLAVES] = '{
    axi_ic_pkg::sram_end,
    axi_ic_pkg::err1_end,
    axi_ic_pkg::periph_end,
    axi_ic_pkg::err2_end
  };

  // regions do not overlap, so at most one bit comes out set
  always_comb begin
    for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
      sel[i] = (addr >= region_lo[i]) && (addr <= region_hi[i]);
    end
  end

  assign valid_s = sel & {axi_ic_pkg::NUM_SLAVES{valid}};

  // an address outside every region never gets ready
  assign ready = |(sel & ready_s);

endmodule

`default_nettype wire

// File: rtl/write_addr_table.sv
`default_nettype none

module write_addr_table #(
  parameter int unsigned ADDR_W = axi_ic_pkg::ADDR_BITS,
  parameter int unsigned ID_W   = 8
) (
  input  wire logic                   aclk,
  input  wire logic                   aresetn,
  input  wire logic [ID_W-1:0]        awid,
  input  wire logic [ADDR_W-1:0]      awaddr,
  input  wire axi_ic_pkg::slave_sel_t aw_sel,
  input  wire logic                   aw_fire,
  input  wire logic [ID_W-1:0]        wid,
  input  wire axi_ic_pkg::slave_sel_t w_sel,
  input  wire logic                   w_last_fire,
  output logic      [ADDR_W-1:0]      w_addr
);

  logic [ID_W-1:0]   id_q   [axi_ic_pkg::NUM_SLAVES];
  logic [ADDR_W-1:0] addr_q [axi_ic_pkg::NUM_SLAVES];

  // an entry with id zero counts as empty, so the whole table must come up cleared
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
        id_q[i]   <= '0;
        addr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
        if (aw_fire && aw_sel[i]) begin
          id_q[i]   <= awid;
          addr_q[i] <= awaddr;
        end else if (w_last_fire && w_sel[i]) begin
          id_q[i]   <= '0;  // burst finished on this slave
          addr_q[i] <= '0;
        end
      end
    end
  end

  // first matching entry wins; a miss returns zero which decodes to sram
  always_comb begin
    logic found;
    found  = 1'b0;
    w_addr = '0;
    if (wid != '0) begin
      for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
        if (!found && (wid == id_q[i])) begin
          found  = 1'b1;
          w_addr = addr_q[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/b_arbiter.sv
`default_nettype none

module b_arbiter #(
  parameter int unsigned ID_W = 8
) (
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]             bvalid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0][ID_W-1:0]   bid_s,
  input  wire axi_ic_pkg::resp_t [axi_ic_pkg::NUM_SLAVES-1:0] bresp_s,
  input  wire logic                                          bready,
  output logic                                               bvalid,
  output logic      [ID_W-1:0]                               bid,
  output axi_ic_pkg::resp_t                                  bresp,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]             bready_s
);

  axi_ic_pkg::slave_sel_t grant;

  // isolate the lowest set bit, slave 0 always wins
  assign grant = bvalid_s & (~bvalid_s + 1'b1);

  assign bready_s = grant & {axi_ic_pkg::NUM_SLAVES{bready}};

  always_comb begin
    bvalid = 1'b0;
    bid    = '0;
    bresp  = '0;
    for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
      if (grant[i]) begin
        bvalid = 1'b1;
        bid    = bid_s[i];
        bresp  = bresp_s[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/r_arbiter.sv
`default_nettype none

module r_arbiter #(
  parameter int unsigned ID_W   = 8,
  parameter int unsigned DATA_W = 128
) (
  input  wire logic                                           aclk,
  input  wire logic                                           aresetn,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              rvalid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              rlast_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0][ID_W-1:0]    rid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0][DATA_W-1:0]  rdata_s,
  input  wire axi_ic_pkg::resp_t [axi_ic_pkg::NUM_SLAVES-1:0] rresp_s,
  input  wire logic                                           rready,
  output logic                                                rvalid,
  output logic                                                rlast,
  output logic      [ID_W-1:0]                                rid,
  output logic      [DATA_W-1:0]                              rdata,
  output axi_ic_pkg::resp_t                                   rresp,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]              rready_s
);

  axi_ic_pkg::slave_sel_t lock_q;  // set while a granted burst still owes beats
  axi_ic_pkg::slave_sel_t sel;

  // a lock anywhere else blocks this slave, its own lock overrides lower priority
  always_comb begin
    axi_ic_pkg::slave_sel_t own;
    logic other_lock;
    logic lower_valid;
    for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
      own         = axi_ic_pkg::slave_sel_t'(1) << i;
      other_lock  = |(lock_q & ~own);
      lower_valid = |(rvalid_s & (own - 1'b1));
      sel[i]      = rvalid_s[i] && !other_lock && (!lower_valid || lock_q[i]);
    end
  end

  // only one slave can be selected, so at most one lock is ever held
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      lock_q <= '0;
    end else begin
      for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
        if (sel[i] && rready && rlast_s[i]) begin
          lock_q[i] <= 1'b0;  // last beat accepted, channel is free again
        end else if (sel[i]) begin
          lock_q[i] <= 1'b1;
        end
      end
    end
  end

  assign rready_s = sel & {axi_ic_pkg::NUM_SLAVES{rready}};

  always_comb begin
    rvalid = 1'b0;
    rlast  = 1'b0;
    rid    = '0;
    rdata  = '0;
    rresp  = '0;
    for (int i = 0; i < axi_ic_pkg::NUM_SLAVES; i++) begin
      if (sel[i]) begin
        rvalid = 1'b1;  // sel already implies rvalid_s
        rlast  = rlast_s[i];
        rid    = rid_s[i];
        rdata  = rdata_s[i];
        rresp  = rresp_s[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/axi_interconnect.sv
`default_nettype none

module axi_interconnect #(
  parameter int unsigned ADDR_W = axi_ic_pkg::ADDR_BITS,
  parameter int unsigned ID_W   = 8,
  parameter int unsigned DATA_W = 128
) (
  input  wire logic                                           aclk,
  input  wire logic                                           aresetn,

  // master side
  input  wire logic [ADDR_W-1:0]                              awaddr,
  input  wire logic [ID_W-1:0]                                awid,
  input  wire logic                                           awvalid,
  output logic                                                awready,
  input  wire logic [ID_W-1:0]                                wid,
  input  wire logic                                           wlast,
  input  wire logic                                           wvalid,
  output logic                                                wready,
  output logic      [ID_W-1:0]                                bid,
  output axi_ic_pkg::resp_t                                   bresp,
  output logic                                                bvalid,
  input  wire logic                                           bready,
  input  wire logic [ADDR_W-1:0]                              araddr,
  input  wire logic                                           arvalid,
  output logic                                                arready,
  output logic      [ID_W-1:0]                                rid,
  output logic      [DATA_W-1:0]                              rdata,
  output axi_ic_pkg::resp_t                                   rresp,
  output logic                                                rlast,
  output logic                                                rvalid,
  input  wire logic                                           rready,

  // slave side, index i is slave i
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]              awvalid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              awready_s,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]              wvalid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              wready_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              bvalid_s,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]              bready_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0][ID_W-1:0]    bid_s,
  input  wire axi_ic_pkg::resp_t [axi_ic_pkg::NUM_SLAVES-1:0] bresp_s,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]              arvalid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              arready_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              rvalid_s,
  output logic      [axi_ic_pkg::NUM_SLAVES-1:0]              rready_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0][ID_W-1:0]    rid_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0][DATA_W-1:0]  rdata_s,
  input  wire axi_ic_pkg::resp_t [axi_ic_pkg::NUM_SLAVES-1:0] rresp_s,
  input  wire logic [axi_ic_pkg::NUM_SLAVES-1:0]              rlast_s
);

  axi_ic_pkg::slave_sel_t aw_sel;
  axi_ic_pkg::slave_sel_t w_sel;
  logic [ADDR_W-1:0]      w_addr;  // address of the burst that wid belongs to
  logic                   aw_fire;
  logic                   w_last_fire;

  assign aw_fire     = awvalid && awready;
  assign w_last_fire = wvalid && wready && wlast;

  addr_route #(
    .ADDR_W (ADDR_W)
  ) u_aw_route (
    .addr    (awaddr),
    .valid   (awvalid),
    .ready_s (awready_s),
    .valid_s (awvalid_s),
    .ready   (awready),
    .sel     (aw_sel)
  );

  write_addr_table #(
    .ADDR_W (ADDR_W),
    .ID_W   (ID_W)
  ) u_write_addr_table (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .awid        (awid),
    .awaddr      (awaddr),
    .aw_sel      (aw_sel),
    .aw_fire     (aw_fire),
    .wid         (wid),
    .w_sel       (w_sel),
    .w_last_fire (w_last_fire),
    .w_addr      (w_addr)
  );

  // write data has no address of its own, it is steered by the looked up one
  addr_route #(
    .ADDR_W (ADDR_W)
  ) u_w_route (
    .addr    (w_addr),
    .valid   (wvalid),
    .ready_s (wready_s),
    .valid_s (wvalid_s),
    .ready   (wready),
    .sel     (w_sel)
  );

  addr_route #(
    .ADDR_W (ADDR_W)
  ) u_ar_route (
    .addr    (araddr),
    .valid   (arvalid),
    .ready_s (arready_s),
    .valid_s (arvalid_s),
    .ready   (arready),
    .sel     ()
  );

  b_arbiter #(
    .ID_W (ID_W)
  ) u_b_arbiter (
    .bvalid_s (bvalid_s),
    .bid_s    (bid_s),
    .bresp_s  (bresp_s),
    .bready   (bready),
    .bvalid   (bvalid),
    .bid      (bid),
    .bresp    (bresp),
    .bready_s (bready_s)
  );

  r_arbiter #(
    .ID_W   (ID_W),
    .DATA_W (DATA_W)
  ) u_r_arbiter (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .rvalid_s (rvalid_s),
    .rlast_s  (rlast_s),
    .rid_s    (rid_s),
    .rdata_s  (rdata_s),
    .rresp_s  (rresp_s),
    .rready   (rready),
    .rvalid   (rvalid),
    .rlast    (rlast),
    .rid      (rid),
    .rdata    (rdata),
    .rresp    (rresp),
    .rready_s (rready_s)
  );

endmodule

`default_nettype wire

// File: tb/tb_axi_interconnect.sv
`default_nettype none

module tb_axi_interconnect;

  localparam int unsigned N       = axi_ic_pkg::NUM_SLAVES;
  localparam int unsigned ADDR_W  = axi_ic_pkg::ADDR_BITS;
  localparam int unsigned ID_W    = 8;
  localparam int unsigned DATA_W  = 128;
  localparam int          TIMEOUT = 20;  // cycles any single wait may take
  localparam int          CH_AW   = 0;
  localparam int          CH_AR   = 1;
  localparam int          CH_W    = 2;
  localparam int          CH_R    = 3;

  logic aclk, aresetn;
  logic [ADDR_W-1:0] awaddr, araddr;
  logic [ID_W-1:0] awid, wid, bid, rid;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rlast, rvalid, rready;
  axi_ic_pkg::resp_t bresp, rresp;
  logic [DATA_W-1:0] rdata;
  logic [N-1:0] awvalid_s, awready_s, wvalid_s, wready_s, bvalid_s, bready_s;
  logic [N-1:0] arvalid_s, arready_s, rvalid_s, rready_s, rlast_s;
  logic [N-1:0][ID_W-1:0] bid_s, rid_s;
  logic [N-1:0][DATA_W-1:0] rdata_s;
  axi_ic_pkg::resp_t [N-1:0] bresp_s, rresp_s;

  axi_interconnect u_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_sel(input axi_ic_pkg::slave_sel_t got, input axi_ic_pkg::slave_sel_t exp,
                           input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input axi_ic_pkg::resp_t got, input axi_ic_pkg::resp_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input logic [ID_W-1:0] got, input logic [ID_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // slave k owns region k of the memory map
  function automatic logic [ADDR_W-1:0] region_base(input int k);
    case (k)
      0: return 40'h00_0000_0000;
      1: return 40'h00_0200_0000;
      2: return 40'h00_1000_0000;
      default: return 40'h00_2000_0000;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] region_top(input int k);
    case (k)
      0: return 40'h00_01FF_FFFF;
      1: return 40'h00_0FFF_FFFF;
      2: return 40'h00_1FFF_FFFF;
      default: return 40'hFF_FFFF_FFFF;
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] random_addr(input int k);
    logic [63:0] span;
    logic [63:0] offset;
    span   = 64'(region_top(k)) - 64'(region_base(k)) + 64'd1;
    offset = {$urandom, $urandom} % span;
    return region_base(k) + offset[ADDR_W-1:0];
  endfunction

  function automatic axi_ic_pkg::slave_sel_t one_hot(input int k);
    axi_ic_pkg::slave_sel_t hot;
    hot    = '0;
    hot[k] = 1'b1;
    return hot;
  endfunction

  function automatic logic [DATA_W-1:0] random_data();
    return DATA_W'({$urandom, $urandom, $urandom, $urandom});
  endfunction

  function automatic logic channel_ready(input int ch);
    case (ch)
      CH_AW: return awready;
      CH_AR: return arready;
      CH_W: return wready;
      default: return rvalid && rready;
    endcase
  endfunction

  task automatic wait_ready(input int ch, input string what);
    int cycles;
    cycles = 0;
    while (!channel_ready(ch)) begin
      if (cycles == TIMEOUT) begin
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
        abort_run();
      end else begin
        @(negedge aclk);
        #1;
        cycles++;
      end
    end
  endtask

  task automatic drive_addr_channel(input bit is_read, input logic [ADDR_W-1:0] addr,
                                    input logic valid, input axi_ic_pkg::slave_sel_t ready_s);
    @(negedge aclk);
    if (is_read) begin
      araddr    = addr;
      arvalid   = valid;
      arready_s = ready_s;
    end else begin
      awaddr    = addr;
      awvalid   = valid;
      awready_s = ready_s;
    end
    #1;
  endtask

  task automatic address_routing(input bit is_read);
    logic [ADDR_W-1:0] addr;
    axi_ic_pkg::slave_sel_t hot;
    string chan;
    chan = is_read ? "ar" : "aw";
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < 3; j++) begin
        hot  = one_hot(k);
        addr = (j == 0) ? region_base(k) : (j == 1) ? region_top(k) : random_addr(k);
        drive_addr_channel(is_read, addr, 1'b1, ~hot);  // every slave but the target is ready
        check_sel(is_read ? arvalid_s : awvalid_s, hot,
                  $sformatf("%svalid_s for address %h", chan, addr));
        check_bit(is_read ? arready : awready, 1'b0,
                  $sformatf("%sready with slave %0d stalled", chan, k));
        drive_addr_channel(is_read, addr, 1'b1, hot);
        wait_ready(is_read ? CH_AR : CH_AW, $sformatf("%sready from slave %0d", chan, k));
        drive_addr_channel(is_read, addr, 1'b0, '1);
        check_sel(is_read ? arvalid_s : awvalid_s, '0, $sformatf("%svalid_s while idle", chan));
        check_bit(is_read ? arready : awready, 1'b1,
                  $sformatf("%sready following slave %0d", chan, k));
      end
    end
    drive_addr_channel(is_read, '0, 1'b0, '0);
  endtask

  task automatic write_steering();
    logic [ID_W-1:0] id;
    axi_ic_pkg::slave_sel_t hot;
    for (int k = 0; k < N; k++) begin
      hot = one_hot(k);
      id  = ID_W'($urandom_range((1 << ID_W) - 1, 1));  // zero would mean no entry
      @(negedge aclk);
      awaddr    = random_addr(k);
      awid      = id;
      awvalid   = 1'b1;
      awready_s = '1;
      #1;
      wait_ready(CH_AW, "awready for the write burst");
      @(negedge aclk);
      awvalid   = 1'b0;
      awid      = '0;
      awready_s = '0;
      wid       = id;
      wvalid    = 1'b1;
      wlast     = 1'b0;
      wready_s  = '0;
      #1;
      check_sel(wvalid_s, hot, $sformatf("wvalid_s for wid %0h to region %0d", id, k));
      check_bit(wready, 1'b0, "wready with every slave stalled");
      @(negedge aclk);
      wready_s = ~hot;
      #1;
      check_bit(wready, 1'b0, "wready with only other slaves ready");
      @(negedge aclk);
      wready_s = hot;
      #1;
      wait_ready(CH_W, "wready for the first beat");
      @(negedge aclk);
      wlast = 1'b1;
      #1;
      check_sel(wvalid_s, hot, "wvalid_s on the last beat");
      wait_ready(CH_W, "wready for the last beat");
      @(negedge aclk);
      wlast    = 1'b0;
      wready_s = '0;
      #1;
      check_sel(wvalid_s, one_hot(0), "wvalid_s for a wid whose burst has ended");
      @(negedge aclk);
      wid = '0;
      #1;
      check_sel(wvalid_s, one_hot(0), "wvalid_s for wid zero");
      @(negedge aclk);
      wvalid = 1'b0;
      #1;
      check_sel(wvalid_s, '0, "wvalid_s while idle");
    end
  endtask

  task automatic write_response_priority();
    logic exp_valid;
    logic [ID_W-1:0] exp_id;
    axi_ic_pkg::resp_t exp_resp;
    axi_ic_pkg::slave_sel_t exp_ready;
    for (int n = 0; n < (1 << N); n++) begin
      @(negedge aclk);
      bvalid_s = N'(n);  // walks every subset of responding slaves
      bready   = 1'($urandom);
      for (int i = 0; i < N; i++) begin
        bid_s[i]   = ID_W'($urandom);
        bresp_s[i] = axi_ic_pkg::resp_t'($urandom);
      end
      #1;
      exp_valid = 1'b0;
      exp_id    = '0;
      exp_resp  = '0;
      exp_ready = '0;
      for (int i = N - 1; i >= 0; i--) begin
        if (bvalid_s[i]) begin
          exp_valid = 1'b1;
          exp_id    = bid_s[i];
          exp_resp  = bresp_s[i];
          exp_ready = bready ? one_hot(i) : '0;
        end
      end
      check_bit(bvalid, exp_valid, $sformatf("bvalid for bvalid_s %b", bvalid_s));
      check_id(bid, exp_id, $sformatf("bid for bvalid_s %b", bvalid_s));
      check_resp(bresp, exp_resp, $sformatf("bresp for bvalid_s %b", bvalid_s));
      check_sel(bready_s, exp_ready, $sformatf("bready_s for bvalid_s %b", bvalid_s));
    end
    @(negedge aclk);
    bvalid_s = '0;
    bready   = 1'b0;
  endtask

  task automatic expect_read_idle(input string when);
    check_bit(rvalid, 1'b0, {"rvalid ", when});
    check_bit(rlast, 1'b0, {"rlast ", when});
    check_id(rid, '0, {"rid ", when});
    check_data(rdata, '0, {"rdata ", when});
    check_resp(rresp, '0, {"rresp ", when});
    check_sel(rready_s, '0, {"rready_s ", when});
  endtask

  task automatic read_burst_lock();
    logic [ID_W-1:0] id_a;
    logic [ID_W-1:0] id_b;
    logic [DATA_W-1:0] data_a;
    logic [DATA_W-1:0] data_b;
    axi_ic_pkg::resp_t resp_b;
    id_a   = ID_W'($urandom);
    id_b   = ID_W'($urandom);
    data_a = random_data();
    data_b = random_data();
    resp_b = axi_ic_pkg::resp_t'($urandom);
    @(negedge aclk);
    rready = 1'b1;
    #1;
    expect_read_idle("with no slave responding");
    @(negedge aclk);
    rvalid_s   = one_hot(2);
    rid_s[2]   = id_a;
    rdata_s[2] = data_a;
    rresp_s[2] = 2'b10;
    #1;
    wait_ready(CH_R, "first read beat of slave 2");
    check_sel(rready_s, one_hot(2), "rready_s on the first beat of slave 2");
    check_data(rdata, data_a, "rdata on the first beat of slave 2");
    check_resp(rresp, 2'b10, "rresp on the first beat of slave 2");
    @(negedge aclk);
    data_a     = random_data();
    rdata_s[2] = data_a;
    rvalid_s   = one_hot(0) | one_hot(2);  // slave 0 outranks slave 2 but arrives mid burst
    rid_s[0]   = id_b;
    rdata_s[0] = data_b;
    rresp_s[0] = resp_b;
    rlast_s[0] = 1'b1;
    #1;
    check_sel(rready_s, one_hot(2), "rready_s while slave 2 owns the burst");
    check_id(rid, id_a, "rid while slave 2 owns the burst");
    check_data(rdata, data_a, "rdata while slave 2 owns the burst");
    @(negedge aclk);
    rready = 1'b0;
    #1;
    check_sel(rready_s, '0, "rready_s with the master stalled");
    check_id(rid, id_a, "rid with the master stalled");
    @(negedge aclk);
    rready     = 1'b1;
    rlast_s[2] = 1'b1;
    #1;
    wait_ready(CH_R, "last read beat of slave 2");
    check_bit(rlast, 1'b1, "rlast on the last beat of slave 2");
    check_id(rid, id_a, "rid on the last beat of slave 2");
    check_sel(rready_s, one_hot(2), "rready_s on the last beat of slave 2");
    @(negedge aclk);
    rlast_s[2] = 1'b0;
    #1;
    check_sel(rready_s, one_hot(0), "rready_s once slave 2 released the channel");
    check_id(rid, id_b, "rid once slave 2 released the channel");
    check_data(rdata, data_b, "rdata once slave 2 released the channel");
    check_resp(rresp, resp_b, "rresp once slave 2 released the channel");
    check_bit(rlast, 1'b1, "rlast of the single beat from slave 0");
    @(negedge aclk);
    rvalid_s = '0;
    rlast_s  = '0;
    #1;
    expect_read_idle("after both bursts");
  endtask

  initial begin
    void'($urandom(88545));
    aresetn   = 1'b0;
    awaddr    = '0;
    awid      = '0;
    awvalid   = 1'b0;
    wid       = '0;
    wlast     = 1'b0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    awready_s = '0;
    wready_s  = '0;
    bvalid_s  = '0;
    bid_s     = '0;
    bresp_s   = '0;
    arready_s = '0;
    rvalid_s  = '0;
    rid_s     = '0;
    rdata_s   = '0;
    rresp_s   = '0;
    rlast_s   = '0;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    address_routing(1'b0);
    address_routing(1'b1);
    write_steering();
    write_response_priority();
    read_burst_lock();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/axi_ic_pkg.sv
rtl/addr_route.sv
rtl/write_addr_table.sv
rtl/b_arbiter.sv
rtl/r_arbiter.sv
rtl/axi_interconnect.sv
tb/tb_axi_interconnect.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_interconnect
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
